/* src/d2d_link_pkg.sv */
/* Shared widths, types and the LPIF flit layout for the four-channel link.
   Channel count and slice layout are fixed; the last lane carries 132 flit bits. */

package d2d_link_pkg;

  ////////////////////////////////////////////////////////////
  // Link geometry

  localparam int NUM_LANES = 4;
  localparam int LANE_W    = 160;
  localparam int FLIT_W    = 537;
  localparam int DATA_W    = 512;

  // Flit bits carried per lane
  localparam int SLICE_W   = 135;

  // Strobe and marker positions in a lane word
  localparam int STB_BIT   = 135;
  localparam int MRK_BIT   = 136;
  localparam int MRK_W     = 2;

  // Persistent marker pattern
  localparam logic [MRK_W-1:0] MRK_VAL = 2'b11;

  localparam int DELAY_W   = 16;
  localparam int ERR_W     = 16;

  ////////////////////////////////////////////////////////////
  // Vector types

  typedef logic [LANE_W-1:0]  lane_word_t;
  typedef logic [SLICE_W-1:0] slice_t;
  typedef logic [FLIT_W-1:0]  flit_t;
  typedef logic [DELAY_W-1:0] delay_t;
  typedef logic [ERR_W-1:0]   err_cnt_t;

  ////////////////////////////////////////////////////////////
  // One LPIF transfer, MSB first

  typedef struct packed {
    logic [3:0]        state;
    logic [1:0]        protid;
    logic [DATA_W-1:0] data;
    logic              dvalid;
    logic [15:0]       crc;
    logic              crc_valid;
    logic              valid;
  } lpif_flit_s;

  // Online delay FSM, one per direction
  typedef enum logic [1:0] {
    SYNC_OFF  = 2'd0,
    SYNC_WAIT = 2'd1,
    SYNC_ON   = 2'd2
  } sync_state_e;

endpackage

/* src/link_auto_sync.sv */
/* Delay value is sampled while waiting; zero and one both go online on the next edge.
   Dropping a request clears its delayed flag on the following edge. */

`timescale 1ns/10ps

module link_auto_sync (
  input  logic                 clk_wr,
  input  logic                 rst_n,
  input  logic                 tx_online,
  input  logic                 rx_online,
  input  d2d_link_pkg::delay_t delay_x_value,
  input  d2d_link_pkg::delay_t delay_y_value,
  output logic                 tx_online_delay,
  output logic                 rx_online_delay
);

  // Index 0 is transmit, index 1 is receive
  logic                 online_req [2];
  d2d_link_pkg::delay_t delay_lim  [2];
  logic                 online_dly [2];

  assign online_req[0] = tx_online;
  assign online_req[1] = rx_online;
  assign delay_lim[0]  = delay_x_value;
  assign delay_lim[1]  = delay_y_value;

  ////////////////////////////////////////////////////////////
  // Per-direction delay FSM

  for (genvar d = 0; d < 2; d++) begin : g_dir
    d2d_link_pkg::sync_state_e state_q;
    d2d_link_pkg::delay_t      cnt_q;

    always_ff @(posedge clk_wr or negedge rst_n) begin
      if (!rst_n) begin
        state_q <= d2d_link_pkg::SYNC_OFF;
        cnt_q   <= '0;
      end else if (!online_req[d]) begin
        state_q <= d2d_link_pkg::SYNC_OFF;
        cnt_q   <= '0;
      end else begin
        case (state_q)
          d2d_link_pkg::SYNC_OFF: begin
            // First edge with the request high counts as zero
            state_q <= d2d_link_pkg::SYNC_WAIT;
            cnt_q   <= d2d_link_pkg::delay_t'(1);
          end
          d2d_link_pkg::SYNC_WAIT: begin
            if (cnt_q >= delay_lim[d]) begin
              state_q <= d2d_link_pkg::SYNC_ON;
            end else begin
              cnt_q <= cnt_q + 1'b1;
            end
          end
          d2d_link_pkg::SYNC_ON: begin
            state_q <= d2d_link_pkg::SYNC_ON;
          end
          default: begin
            state_q <= d2d_link_pkg::SYNC_OFF;
            cnt_q   <= '0;
          end
        endcase
      end
    end

    assign online_dly[d] = (state_q == d2d_link_pkg::SYNC_ON);
  end

  assign tx_online_delay = online_dly[0];
  assign rx_online_delay = online_dly[1];

endmodule

/* src/flit_stripe.sv */
/* One flit is accepted every cycle; there is no back-pressure.
   Lane 0 takes the least significant bits, the last lane is zero padded. */

`timescale 1ns/10ps

module flit_stripe (
  input  logic                     clk_wr,
  input  logic                     rst_n,
  input  d2d_link_pkg::lpif_flit_s ustrm,
  output d2d_link_pkg::slice_t     tx_slice [d2d_link_pkg::NUM_LANES]
);

  localparam int PAD_W =
    d2d_link_pkg::NUM_LANES * d2d_link_pkg::SLICE_W - d2d_link_pkg::FLIT_W;

  d2d_link_pkg::flit_t flit_q;

  // Flit widened to a whole number of slices
  logic [d2d_link_pkg::NUM_LANES*d2d_link_pkg::SLICE_W-1:0] flit_pad;

  ////////////////////////////////////////////////////////////
  // Input register

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      flit_q <= '0;
    end else begin
      flit_q <= ustrm;
    end
  end

  assign flit_pad = {{PAD_W{1'b0}}, flit_q};

  ////////////////////////////////////////////////////////////
  // Slice split

  for (genvar l = 0; l < d2d_link_pkg::NUM_LANES; l++) begin : g_slice
    assign tx_slice[l] = flit_pad[l*d2d_link_pkg::SLICE_W +: d2d_link_pkg::SLICE_W];
  end

endmodule

/* src/phy_lane.sv */
/* Strobe and marker are always inserted; the word is all zero while offline.
   One register stage in each direction. */

`timescale 1ns/10ps

module phy_lane (
  input  logic                     clk_wr,
  input  logic                     rst_n,
  input  logic                     tx_online,
  input  d2d_link_pkg::slice_t     tx_slice,
  input  d2d_link_pkg::lane_word_t rx_phy,
  output d2d_link_pkg::lane_word_t tx_phy,
  output d2d_link_pkg::slice_t     rx_slice,
  output logic                     strobe_ok
);

  d2d_link_pkg::lane_word_t tx_word;
  d2d_link_pkg::lane_word_t rx_q;

  ////////////////////////////////////////////////////////////
  // Transmit word build

  always_comb begin
    tx_word = '0;
    tx_word[d2d_link_pkg::SLICE_W-1:0] = tx_slice;
    tx_word[d2d_link_pkg::STB_BIT]     = 1'b1;
    tx_word[d2d_link_pkg::MRK_BIT +: d2d_link_pkg::MRK_W] = d2d_link_pkg::MRK_VAL;
  end

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_phy <= '0;
    end else if (tx_online) begin
      tx_phy <= tx_word;
    end else begin
      // Idle line while offline
      tx_phy <= '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Receive capture

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_q <= '0;
    end else begin
      rx_q <= rx_phy;
    end
  end

  assign rx_slice = rx_q[d2d_link_pkg::SLICE_W-1:0];

  // Word is aligned when strobe and marker both match
  assign strobe_ok = rx_q[d2d_link_pkg::STB_BIT] &&
                     (rx_q[d2d_link_pkg::MRK_BIT +: d2d_link_pkg::MRK_W] ==
                      d2d_link_pkg::MRK_VAL);

endmodule

/* src/flit_destripe.sv */
/* Qualifiers are cleared unless online and all four lanes are aligned.
   The misalignment counter saturates and is only cleared by reset. */

`timescale 1ns/10ps

module flit_destripe (
  input  logic                                  clk_wr,
  input  logic                                  rst_n,
  input  logic                                  rx_online,
  input  d2d_link_pkg::slice_t                  rx_slice [d2d_link_pkg::NUM_LANES],
  input  logic [d2d_link_pkg::NUM_LANES-1:0]    strobe_ok,
  output d2d_link_pkg::lpif_flit_s              dstrm,
  output d2d_link_pkg::err_cnt_t                err_cnt
);

  // Four slices back to back, top pad bits dropped below
  logic [d2d_link_pkg::NUM_LANES*d2d_link_pkg::SLICE_W-1:0] lanes_cat;

  d2d_link_pkg::flit_t      flit_rx;
  d2d_link_pkg::lpif_flit_s flit_nxt;
  logic                     aligned;

  for (genvar l = 0; l < d2d_link_pkg::NUM_LANES; l++) begin : g_cat
    assign lanes_cat[l*d2d_link_pkg::SLICE_W +: d2d_link_pkg::SLICE_W] = rx_slice[l];
  end

  assign flit_rx = lanes_cat[d2d_link_pkg::FLIT_W-1:0];
  assign aligned = rx_online && (&strobe_ok);

  ////////////////////////////////////////////////////////////
  // Delivery gating

  always_comb begin
    flit_nxt = flit_rx;
    if (!aligned) begin
      flit_nxt.valid     = 1'b0;
      flit_nxt.dvalid    = 1'b0;
      flit_nxt.crc_valid = 1'b0;
    end
  end

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      dstrm <= '0;
    end else begin
      dstrm <= flit_nxt;
    end
  end

  ////////////////////////////////////////////////////////////
  // Misalignment counter

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      err_cnt <= '0;
    end else if (rx_online && !(&strobe_ok) && (err_cnt != '1)) begin
      err_cnt <= err_cnt + 1'b1;
    end
  end

endmodule

/* src/d2d_link_top.sv */
/* Single clock, no back-pressure; ustrm to tx_phy and rx_phy to dstrm are 2 cycles each.
   link_status is {tx_online_delay, rx_online_delay, 14'b0, misalignment count}. */

`timescale 1ns/10ps

module d2d_link_top (
  input  logic                     clk_wr,
  input  logic                     rst_n,

  // Control
  input  logic                     tx_online,
  input  logic                     rx_online,
  input  d2d_link_pkg::delay_t     delay_x_value,
  input  d2d_link_pkg::delay_t     delay_y_value,

  // User side
  input  d2d_link_pkg::lpif_flit_s ustrm,
  output d2d_link_pkg::lpif_flit_s dstrm,

  // PHY side
  output d2d_link_pkg::lane_word_t tx_phy [d2d_link_pkg::NUM_LANES],
  input  d2d_link_pkg::lane_word_t rx_phy [d2d_link_pkg::NUM_LANES],

  // Status
  output logic [31:0]              link_status
);

  ////////////////////////////////////////////////////////////
  // Interconnect

  logic                                 tx_online_delay;
  logic                                 rx_online_delay;
  d2d_link_pkg::slice_t                 tx_slice  [d2d_link_pkg::NUM_LANES];
  d2d_link_pkg::slice_t                 rx_slice  [d2d_link_pkg::NUM_LANES];
  logic [d2d_link_pkg::NUM_LANES-1:0]   strobe_ok;
  d2d_link_pkg::err_cnt_t               err_cnt;

  ////////////////////////////////////////////////////////////
  // Auto sync

  link_auto_sync link_auto_sync_i (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay)
  );

  ////////////////////////////////////////////////////////////
  // Transmit split

  flit_stripe flit_stripe_i (
    .clk_wr   (clk_wr),
    .rst_n    (rst_n),
    .ustrm    (ustrm),
    .tx_slice (tx_slice)
  );

  ////////////////////////////////////////////////////////////
  // PHY channels

  for (genvar l = 0; l < d2d_link_pkg::NUM_LANES; l++) begin : g_lane
    phy_lane phy_lane_i (
      .clk_wr    (clk_wr),
      .rst_n     (rst_n),
      .tx_online (tx_online_delay),
      .tx_slice  (tx_slice[l]),
      .rx_phy    (rx_phy[l]),
      .tx_phy    (tx_phy[l]),
      .rx_slice  (rx_slice[l]),
      .strobe_ok (strobe_ok[l])
    );
  end

  ////////////////////////////////////////////////////////////
  // Receive rebuild

  flit_destripe flit_destripe_i (
    .clk_wr    (clk_wr),
    .rst_n     (rst_n),
    .rx_online (rx_online_delay),
    .rx_slice  (rx_slice),
    .strobe_ok (strobe_ok),
    .dstrm     (dstrm),
    .err_cnt   (err_cnt)
  );

  // Status word
  assign link_status = {tx_online_delay, rx_online_delay, 14'b0, err_cnt};

endmodule

/* verification/tb_d2d_link.sv */
/* Loopback testbench for d2d_link_top; rx_phy mirrors tx_phy, with strobes cleared per row.
   A row is checked on tx_phy 2 cycles and on dstrm 4 cycles after it is driven. */

`timescale 1ns/10ps

module tb_d2d_link;

  localparam int NUM_ROWS = 8;
  localparam int DLY_X    = 5;
  localparam int DLY_Y    = 3;

  // Two table passes, both online delays and margin, at two periods per step
  localparam int WATCHDOG_NS = (2 * NUM_ROWS + DLY_X + DLY_Y + 20) * 4 * 2;

  localparam logic [1:0] FILL_ZERO = 2'd0;
  localparam logic [1:0] FILL_ONES = 2'd1;
  localparam logic [1:0] FILL_LFSR = 2'd2;

  typedef struct packed {
    logic [3:0]  state;
    logic [1:0]  protid;
    logic [15:0] crc;
    logic        valid;
    logic        dvalid;
    logic        crc_valid;
    logic [3:0]  corrupt;
    logic [1:0]  fill;
    logic        exp_aligned;
  } row_s;

  // state, protid, crc, valid, dvalid, crc_valid, corrupt lanes, fill, aligned
  row_s rows [NUM_ROWS] = '{
    '{4'h1, 2'd0, 16'hbeef, 1'b1, 1'b1, 1'b1, 4'b0000, FILL_LFSR, 1'b1},
    '{4'h2, 2'd1, 16'h1234, 1'b1, 1'b1, 1'b1, 4'b0000, FILL_ONES, 1'b1},
    '{4'h3, 2'd2, 16'h0000, 1'b1, 1'b0, 1'b1, 4'b0000, FILL_ZERO, 1'b1},
    '{4'hf, 2'd3, 16'ha5a5, 1'b1, 1'b1, 1'b1, 4'b0001, FILL_LFSR, 1'b0},
    '{4'h4, 2'd0, 16'h5a5a, 1'b1, 1'b1, 1'b1, 4'b0000, FILL_LFSR, 1'b1},
    '{4'h5, 2'd1, 16'hffff, 1'b1, 1'b1, 1'b1, 4'b1000, FILL_ONES, 1'b0},
    '{4'h6, 2'd2, 16'h0f0f, 1'b1, 1'b1, 1'b1, 4'b1100, FILL_LFSR, 1'b0},
    '{4'h7, 2'd3, 16'h7777, 1'b1, 1'b1, 1'b0, 4'b0000, FILL_LFSR, 1'b1}
  };

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic                     tx_online;
  logic                     rx_online;
  d2d_link_pkg::delay_t     delay_x_value;
  d2d_link_pkg::delay_t     delay_y_value;
  d2d_link_pkg::lpif_flit_s ustrm;
  d2d_link_pkg::lpif_flit_s dstrm;
  d2d_link_pkg::lane_word_t tx_phy [d2d_link_pkg::NUM_LANES];
  d2d_link_pkg::lane_word_t rx_phy [d2d_link_pkg::NUM_LANES];
  logic [31:0]              link_status;

  logic [3:0]               corrupt;
  logic [3:0]               corrupt_d1 = '0;
  logic [3:0]               corrupt_d2 = '0;
  logic [31:0]              lfsr;
  d2d_link_pkg::lpif_flit_s sent [NUM_ROWS];
  d2d_link_pkg::err_cnt_t   exp_err;
  int                       errors;
  int                       checks;
  int                       tests;

  always #2 clk = ~clk;

  d2d_link_top dut0 (
    .clk_wr        (clk),
    .rst_n         (rst_n),
    .tx_online     (tx_online),
    .rx_online     (rx_online),
    .delay_x_value (delay_x_value),
    .delay_y_value (delay_y_value),
    .ustrm         (ustrm),
    .dstrm         (dstrm),
    .tx_phy        (tx_phy),
    .rx_phy        (rx_phy),
    .link_status   (link_status)
  );

  ////////////////////////////////////////////////////////////
  // PHY loopback, mask follows its flit through the 2-cycle tx path

  always @(posedge clk) begin
    corrupt_d1 <= corrupt;
    corrupt_d2 <= corrupt_d1;
  end

  for (genvar l = 0; l < d2d_link_pkg::NUM_LANES; l++) begin : g_loop
    assign rx_phy[l] = corrupt_d2[l] ?
      (tx_phy[l] & ~(d2d_link_pkg::lane_word_t'(1) << d2d_link_pkg::STB_BIT)) : tx_phy[l];
  end

  ////////////////////////////////////////////////////////////
  // Stimulus and expected values

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  task automatic build_flit(input row_s r, output d2d_link_pkg::lpif_flit_s f);
    f           = '0;
    f.state     = r.state;
    f.protid    = r.protid;
    f.crc       = r.crc;
    f.valid     = r.valid;
    f.dvalid    = r.dvalid;
    f.crc_valid = r.crc_valid;
    for (int b = 0; b < d2d_link_pkg::DATA_W; b++) begin
      case (r.fill)
        FILL_ONES: f.data[b] = 1'b1;
        FILL_LFSR: begin
          f.data[b] = lfsr[0];
          lfsr      = lfsr_next(lfsr);
        end
        default: f.data[b] = 1'b0;
      endcase
    end
  endtask

  // Slice bits, strobe at 135, marker 2'b11 at 136, zero above
  function automatic d2d_link_pkg::lane_word_t lane_of(input d2d_link_pkg::lpif_flit_s f,
                                                       input int l);
    d2d_link_pkg::lane_word_t w;
    d2d_link_pkg::flit_t      v;
    int                       idx;
    w = '0;
    v = f;
    for (int b = 0; b < d2d_link_pkg::SLICE_W; b++) begin
      idx = l * d2d_link_pkg::SLICE_W + b;
      if (idx < d2d_link_pkg::FLIT_W) begin
        w[b] = v[idx];
      end
    end
    w[135] = 1'b1;
    w[136] = 1'b1;
    w[137] = 1'b1;
    return w;
  endfunction

  function automatic d2d_link_pkg::lpif_flit_s delivered(input d2d_link_pkg::lpif_flit_s f,
                                                         input logic ok);
    d2d_link_pkg::lpif_flit_s d;
    d = f;
    if (!ok) begin
      d.valid     = 1'b0;
      d.dvalid    = 1'b0;
      d.crc_valid = 1'b0;
    end
    return d;
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks

  task automatic check_flit(input string name, input d2d_link_pkg::lpif_flit_s got,
                            input d2d_link_pkg::lpif_flit_s exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_lane(input string name, input d2d_link_pkg::lane_word_t got,
                            input d2d_link_pkg::lane_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_cnt(input string name, input d2d_link_pkg::err_cnt_t got,
                           input d2d_link_pkg::err_cnt_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_status(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_delay(input string name, input d2d_link_pkg::delay_t got,
                             input d2d_link_pkg::delay_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0t %s edges got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR t=%0t %s", $time, msg);
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests++;
    $display("test %-16s done, %0d errors", name, errors - err_start);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequences

  // Caller drives the request on the edge before this task
  task automatic measure_online(input int bit_idx, input d2d_link_pkg::delay_t exp,
                                input string name);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    @(posedge clk);
    @(negedge clk);
    if (link_status[bit_idx]) begin
      report_error({name, " rose on the edge that sampled the request"});
    end
    while (!seen && n < 64) begin
      // Idle line while transmit is still offline
      for (int l = 0; l < d2d_link_pkg::NUM_LANES && bit_idx == 31; l++) begin
        check_lane($sformatf("tx_phy[%0d]", l), tx_phy[l], '0);
      end
      @(posedge clk);
      n++;
      @(negedge clk);
      seen = link_status[bit_idx];
    end
    if (!seen) begin
      report_error({name, " never rose after its online request"});
    end else begin
      check_delay(name, d2d_link_pkg::delay_t'(n), exp);
    end
  endtask

  // One row per cycle with no gaps, then four drain cycles
  task automatic run_table(input logic online);
    d2d_link_pkg::lpif_flit_s f;
    logic                     ok;
    for (int j = 0; j < NUM_ROWS + 4; j++) begin
      @(posedge clk);
      if (j < NUM_ROWS) begin
        build_flit(rows[j], f);
        sent[j] = f;
        ustrm   <= f;
        corrupt <= rows[j].corrupt;
      end else begin
        ustrm   <= '0;
        corrupt <= '0;
      end
      @(negedge clk);
      if (j >= 2 && j < NUM_ROWS + 2) begin
        for (int l = 0; l < d2d_link_pkg::NUM_LANES; l++) begin
          check_lane($sformatf("tx_phy[%0d] row %0d", l, j - 2), tx_phy[l],
                     lane_of(sent[j-2], l));
        end
      end
      if (j >= 4) begin
        ok = online && rows[j-4].exp_aligned;
        if (online && !rows[j-4].exp_aligned) begin
          exp_err = exp_err + 1'b1;
        end
        check_flit($sformatf("dstrm row %0d", j - 4), dstrm, delivered(sent[j-4], ok));
        check_cnt("err_cnt", link_status[15:0], exp_err);
        // Both online flags, the zero field and the counter
        check_status("link_status", link_status, {1'b1, online, 14'b0, exp_err});
      end
    end
  endtask

  initial begin
    int                       err_start;
    d2d_link_pkg::lpif_flit_s probe;
    rst_n         = 1'b0;
    tx_online     = 1'b0;
    rx_online     = 1'b0;
    delay_x_value = DLY_X;
    delay_y_value = DLY_Y;
    ustrm         = '0;
    corrupt       = '0;
    lfsr          = 32'hd703_6824;
    exp_err       = '0;
    errors        = 0;
    checks        = 0;
    tests         = 0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // Offline with a valid flit at the input
    err_start = errors;
    build_flit(rows[0], probe);
    @(posedge clk);
    ustrm <= probe;
    repeat (4) begin
      @(posedge clk);
      @(negedge clk);
      for (int l = 0; l < d2d_link_pkg::NUM_LANES; l++) begin
        check_lane($sformatf("tx_phy[%0d]", l), tx_phy[l], '0);
      end
      check_flit("dstrm", dstrm, '0);
      check_cnt("err_cnt", link_status[15:0], '0);
      check_status("link_status", link_status, '0);
    end
    finish_test("reset_offline", err_start);

    err_start = errors;
    @(posedge clk);
    tx_online <= 1'b1;
    measure_online(31, DLY_X, "tx_online_delay");
    finish_test("tx_online_delay", err_start);

    // Aligned words reach the receive capture before rx goes online
    repeat (3) @(posedge clk);
    err_start = errors;
    rx_online <= 1'b1;
    measure_online(30, DLY_Y, "rx_online_delay");
    finish_test("rx_online_delay", err_start);

    err_start = errors;
    run_table(1'b1);
    finish_test("loopback", err_start);

    err_start = errors;
    @(posedge clk);
    rx_online <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    if (link_status[30] !== 1'b0) begin
      report_error("rx_online_delay still set one edge after rx_online dropped");
    end
    run_table(1'b0);
    finish_test("link_drop", err_start);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before the test sequence completed", WATCHDOG_NS);
    $display("Some tests failed");
    $finish;
  end

endmodule

/* list.f */
src/d2d_link_pkg.sv
src/link_auto_sync.sv
src/flit_stripe.sv
src/phy_lane.sv
src/flit_destripe.sv
src/d2d_link_top.sv
verification/tb_d2d_link.sv
